/* backup_arbiter.sv */
`timescale 1ns/100ps

module backup_arbiter import sms_pkg::*; #(
	parameter int BK_SECTORS = 64
) (
	input  logic                                         clk_sys,
	input  logic                                         reset,
	input  logic                                         nvram_sel,
	input  logic [$clog2(BK_SECTORS)+SECTOR_ADDR_W-1:0] nvram_a,
	input  logic                                         nvram_we,
	input  logic [7:0]                                   nvram_d,
	input  logic                                         sd_ack,
	input  logic [$clog2(BK_SECTORS)-1:0]               sd_lba_low,
	input  logic [SECTOR_ADDR_W-1:0]                    sd_buff_addr,
	input  logic                                         sd_buff_wr,
	input  logic [7:0]                                   sd_buff_dout,
	input  logic [7:0]                                   ram_q,
	output logic [7:0]                                   nvram_q,
	output logic [7:0]                                   sd_buff_din,
	output logic                                         sd_buff_stall,
	output logic [$clog2(BK_SECTORS)+SECTOR_ADDR_W-1:0] ram_a,
	output logic                                         ram_we,
	output logic [7:0]                                   ram_d
);

	logic       con_q;
	logic       buf_q;
	logic [7:0] con_hold;
	logic [7:0] buf_hold;

	// Console always wins, the buffer side retries the stalled cycle
	assign sd_buff_stall = nvram_sel;
	assign ram_a  = nvram_sel ? nvram_a  : {sd_lba_low, sd_buff_addr};
	assign ram_we = nvram_sel ? nvram_we : (sd_buff_wr & sd_ack);
	assign ram_d  = nvram_sel ? nvram_d  : sd_buff_dout;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			con_q <= 1'b0;
			buf_q <= 1'b0;
		end else begin
			con_q <= nvram_sel;
			buf_q <= ~nvram_sel;
		end
	end

	// Each side keeps its last result while the other owns the RAM
	always_ff @(posedge clk_sys) begin
		if (con_q)
			con_hold <= ram_q;
		if (buf_q)
			buf_hold <= ram_q;
	end

	assign nvram_q     = con_q ? ram_q : con_hold;
	assign sd_buff_din = buf_q ? ram_q : buf_hold;

endmodule

/* backup_ram.sv */
`timescale 1ns/100ps

module backup_ram import sms_pkg::*; #(
	parameter int BK_SECTORS = 64
) (
	input  logic                                         clk_sys,
	input  logic [$clog2(BK_SECTORS*SECTOR_BYTES)-1:0]  ram_a,
	input  logic                                         ram_we,
	input  logic [7:0]                                   ram_d,
	output logic [7:0]                                   ram_q
);

	localparam int DEPTH = BK_SECTORS * SECTOR_BYTES;

	logic [7:0] mem [DEPTH];

	// Read during write returns the previous contents
	always_ff @(posedge clk_sys) begin
		if (ram_we)
			mem[ram_a] <= ram_d;
		ram_q <= mem[ram_a];
	end

endmodule

/* backup_sequencer.sv */
`timescale 1ns/100ps

module backup_sequencer #(
	parameter int BK_SECTORS = 64
) (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        cart_download,
	input  logic        img_mounted,
	input  logic        img_readonly,
	input  logic        img_size_nz,
	input  logic        bk_load,
	input  logic        bk_save,
	input  logic        autosave,
	input  logic        osd_open,
	input  logic        nvram_write,
	input  logic        sd_ack,
	output logic [31:0] sd_lba,
	output logic        sd_rd,
	output logic        sd_wr,
	output logic        bk_busy,
	output logic        bk_loading,
	output logic        bk_pending,
	output logic        bk_ena
);

	logic old_download;
	logic old_load;
	logic old_save;
	logic old_osd;
	logic old_ack;
	logic start_load;
	logic start_save;
	logic last_sector;

	// Menu commands and the download end both count as load requests
	assign start_load = (bk_load & bk_ena & ~old_load) |
		(old_download & ~cart_download & img_size_nz & bk_ena);
	// Autosave fires when the menu opens with unsaved console writes
	assign start_save = (bk_save & bk_ena & ~old_save) |
		(osd_open & ~old_osd & autosave & bk_pending & bk_ena);
	assign last_sector = (sd_lba == 32'(BK_SECTORS - 1));

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_download <= 1'b0;
			old_load     <= 1'b0;
			old_save     <= 1'b0;
			old_osd      <= 1'b0;
			old_ack      <= 1'b0;
		end else begin
			old_download <= cart_download;
			old_load     <= bk_load & bk_ena;
			old_save     <= bk_save & bk_ena;
			old_osd      <= osd_open;
			old_ack      <= sd_ack;
		end
	end

	// Save file gets mounted while the cart is still downloading
	always_ff @(posedge clk_sys) begin
		if (reset)
			bk_ena <= 1'b0;
		else if (cart_download & ~old_download)
			bk_ena <= 1'b0;
		else if (cart_download & img_mounted & ~img_readonly)
			bk_ena <= 1'b1;
	end

	always_ff @(posedge clk_sys) begin
		if (reset)
			bk_pending <= 1'b0;
		else if (bk_ena & ~osd_open & nvram_write)
			bk_pending <= 1'b1;
		else if (bk_busy)
			bk_pending <= 1'b0;
	end

	// ========================================================================
	// Sector loop
	// ========================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			sd_lba     <= '0;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
			bk_busy    <= 1'b0;
			bk_loading <= 1'b0;
		end else begin
			// Host has taken the request
			if (sd_ack & ~old_ack) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end
			if (!bk_busy) begin
				if (start_load | start_save) begin
					bk_busy    <= 1'b1;
					bk_loading <= start_load;
					sd_lba     <= '0;
					sd_rd      <= start_load;
					sd_wr      <= ~start_load;
				end
			end else if (old_ack & ~sd_ack) begin
				if (last_sector) begin
					bk_busy    <= 1'b0;
					bk_loading <= 1'b0;
				end else begin
					sd_lba <= sd_lba + 1'b1;
					sd_rd  <= bk_loading;
					sd_wr  <= ~bk_loading;
				end
			end
		end
	end

endmodule

/* build.f */
sms_pkg.sv
rom_loader.sv
cheat_loader.sv
backup_sequencer.sv
backup_arbiter.sv
backup_ram.sv
cart_host_top.sv
tb_cart_host.sv

/* cart_host_patterns.txt */
# columns: tag op arg data expected (all values hex)
# CART data is index then seed, RDA arg is the console read address
dl_gg_1000    CART 3e8    0237 3e8
rd_hdr_0      RDA  0      0    0
rd_hdr_123    RDA  123    0    123
rd_hdr_1ff    RDA  1ff    0    1ff
rd_hdr_3ff    RDA  3ff    0    1ff
rd_hdr_2345   RDA  2345   0    145
gg_on         GG   0      0    1
dl_sms_1536   CART 600    0155 600
rd_plain_123  RDA  123    0    123
rd_plain_5ff  RDA  5ff    0    5ff
rd_plain_9ab  RDA  9ab    0    1ab
rd_plain_top  RDA  3fffff 0    7ff
gg_off        GG   0      0    0
cheat_load    CODE 10     10   1
cheat_flags   FLG  0      0    43322110
cheat_addr    ADR  0      0    87766554
cheat_cmp     CMP  0      0    cbbaa998
cheat_rep     REP  0      0    0ffeeddc
console_fill  CWR  800    5a   800
save_all      SAVE 0      0    4
load_all      LOAD 0      a7   4
readback      CRD  800    0    800
autosave_osd  AUTO 1a5    c3   4
readback_2    CRD  800    0    800

/* cart_host_top.sv */
`timescale 1ns/100ps

module cart_host_top import sms_pkg::*; #(
	parameter int BK_SECTORS = 64
) (
	input  logic                                         clk_sys,
	input  logic                                         reset,
	// Host download
	input  logic                                         ioctl_download,
	input  logic [7:0]                                   ioctl_index,
	input  logic [IOCTL_ADDR_W-1:0]                     ioctl_addr,
	input  logic [7:0]                                   ioctl_dout,
	input  logic                                         ioctl_wr,
	output logic                                         ioctl_wait,
	// External ROM memory
	output logic                                         rom_wr,
	output logic [ROM_WADDR_W-1:0]                      rom_waddr,
	output logic [7:0]                                   rom_wdata,
	input  logic                                         rom_we_ack,
	input  logic [ROM_ADDR_W-1:0]                       rom_raddr,
	output logic [ROM_ADDR_W-1:0]                       rom_addr,
	output logic                                         gg,
	// Host sector buffer
	output logic [31:0]                                  sd_lba,
	output logic                                         sd_rd,
	output logic                                         sd_wr,
	input  logic                                         sd_ack,
	input  logic [SECTOR_ADDR_W-1:0]                    sd_buff_addr,
	input  logic                                         sd_buff_wr,
	input  logic [7:0]                                   sd_buff_dout,
	output logic [7:0]                                   sd_buff_din,
	output logic                                         sd_buff_stall,
	input  logic                                         img_mounted,
	input  logic                                         img_readonly,
	input  logic                                         img_size_nz,
	// Menu controls
	input  logic                                         bk_load,
	input  logic                                         bk_save,
	input  logic                                         autosave,
	input  logic                                         osd_open,
	// Console backup port
	input  logic                                         nvram_sel,
	input  logic [$clog2(BK_SECTORS)+SECTOR_ADDR_W-1:0] nvram_a,
	input  logic                                         nvram_we,
	input  logic [7:0]                                   nvram_d,
	output logic [7:0]                                   nvram_q,
	output logic                                         bk_busy,
	output logic                                         bk_pending,
	output logic                                         console_reset,
	output logic                                         bk_led,
	output cheat_code_t                                  code,
	output logic                                         code_valid
);

	localparam int SEC_W = $clog2(BK_SECTORS);

	logic                     code_download;
	logic                     cart_download;
	logic                     bk_loading;
	logic [SEC_W+SECTOR_ADDR_W-1:0] ram_a;
	logic                     ram_we;
	logic [7:0]               ram_d;
	logic [7:0]               ram_q;

	assign code_download = ioctl_download & (ioctl_index == CODE_INDEX);
	assign cart_download = ioctl_download & (ioctl_index != CODE_INDEX);

	// Console held in reset while the cart or its save data is loading
	assign console_reset = reset | cart_download | bk_loading;
	assign bk_led = cart_download | bk_busy | (bk_pending & autosave);

	rom_loader u_rom_loader (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.cart_download (cart_download),
		.ioctl_wr      (ioctl_wr),
		.ioctl_addr    (ioctl_addr),
		.ioctl_dout    (ioctl_dout),
		.ioctl_index   (ioctl_index),
		.rom_we_ack    (rom_we_ack),
		.rom_raddr     (rom_raddr),
		.ioctl_wait    (ioctl_wait),
		.rom_wr        (rom_wr),
		.rom_waddr     (rom_waddr),
		.rom_wdata     (rom_wdata),
		.rom_addr      (rom_addr),
		.gg            (gg)
	);

	cheat_loader u_cheat_loader (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.code_download (code_download),
		.ioctl_wr      (ioctl_wr),
		.ioctl_addr    (ioctl_addr),
		.ioctl_dout    (ioctl_dout),
		.code          (code),
		.code_valid    (code_valid)
	);

	backup_sequencer #(.BK_SECTORS(BK_SECTORS)) u_backup_sequencer (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.cart_download (cart_download),
		.img_mounted   (img_mounted),
		.img_readonly  (img_readonly),
		.img_size_nz   (img_size_nz),
		.bk_load       (bk_load),
		.bk_save       (bk_save),
		.autosave      (autosave),
		.osd_open      (osd_open),
		.nvram_write   (nvram_sel & nvram_we),
		.sd_ack        (sd_ack),
		.sd_lba        (sd_lba),
		.sd_rd         (sd_rd),
		.sd_wr         (sd_wr),
		.bk_busy       (bk_busy),
		.bk_loading    (bk_loading),
		.bk_pending    (bk_pending),
		.bk_ena        ()
	);

	backup_arbiter #(.BK_SECTORS(BK_SECTORS)) u_backup_arbiter (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.nvram_sel     (nvram_sel),
		.nvram_a       (nvram_a),
		.nvram_we      (nvram_we),
		.nvram_d       (nvram_d),
		.sd_ack        (sd_ack),
		.sd_lba_low    (sd_lba[SEC_W-1:0]),
		.sd_buff_addr  (sd_buff_addr),
		.sd_buff_wr    (sd_buff_wr),
		.sd_buff_dout  (sd_buff_dout),
		.ram_q         (ram_q),
		.nvram_q       (nvram_q),
		.sd_buff_din   (sd_buff_din),
		.sd_buff_stall (sd_buff_stall),
		.ram_a         (ram_a),
		.ram_we        (ram_we),
		.ram_d         (ram_d)
	);

	backup_ram #(.BK_SECTORS(BK_SECTORS)) u_backup_ram (
		.clk_sys       (clk_sys),
		.ram_a         (ram_a),
		.ram_we        (ram_we),
		.ram_d         (ram_d),
		.ram_q         (ram_q)
	);

endmodule

/* cheat_loader.sv */
`timescale 1ns/100ps

module cheat_loader import sms_pkg::*; (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    code_download,
	input  logic                    ioctl_wr,
	input  logic [IOCTL_ADDR_W-1:0] ioctl_addr,
	input  logic [7:0]              ioctl_dout,
	output cheat_code_t             code,
	output logic                    code_valid
);

	logic       code_wr;
	logic [3:0] byte_sel;

	assign code_wr = code_download & ioctl_wr;

	// Offsets 0..3 land in the top bytes (flags), 12..15 in the bottom
	// (replace), each field little endian by offset
	assign byte_sel = {~ioctl_addr[3:2], ioctl_addr[1:0]};

	always_ff @(posedge clk_sys) begin
		if (code_wr)
			code.bytes[byte_sel] <= ioctl_dout;
	end

	// One pulse once the last byte of the word is in
	always_ff @(posedge clk_sys) begin
		if (reset)
			code_valid <= 1'b0;
		else
			code_valid <= code_wr && (ioctl_addr[3:0] == 4'd15);
	end

endmodule

/* rom_loader.sv */
`timescale 1ns/100ps

module rom_loader import sms_pkg::*; (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    cart_download,
	input  logic                    ioctl_wr,
	input  logic [IOCTL_ADDR_W-1:0] ioctl_addr,
	input  logic [7:0]              ioctl_dout,
	input  logic [7:0]              ioctl_index,
	input  logic                    rom_we_ack,
	input  logic [ROM_ADDR_W-1:0]   rom_raddr,
	output logic                    ioctl_wait,
	output logic                    rom_wr,
	output logic [ROM_WADDR_W-1:0]  rom_waddr,
	output logic [7:0]              rom_wdata,
	output logic [ROM_ADDR_W-1:0]   rom_addr,
	output logic                    gg
);

	logic                  old_download;
	logic                  cart_sz512;
	logic [ROM_ADDR_W-1:0] cart_mask;
	logic [ROM_ADDR_W-1:0] cart_mask512;

	// Toggle handshake towards the ROM memory
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_download <= 1'b0;
			ioctl_wait   <= 1'b0;
			rom_wr       <= 1'b0;
			rom_waddr    <= '0;
		end else begin
			old_download <= cart_download;
			if (ioctl_wr & cart_download) begin
				ioctl_wait <= 1'b1;
				rom_wr     <= ~rom_wr;
			end else if (ioctl_wait && (rom_wr == rom_we_ack)) begin
				// Acknowledged, release the host and advance
				ioctl_wait <= 1'b0;
				rom_waddr  <= rom_waddr + 1'b1;
			end
			if (cart_download & ~old_download)
				rom_waddr <= '0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (ioctl_wr & cart_download)
			rom_wdata <= ioctl_dout;
	end

	// Address masks from the highest bits seen during the download
	always_ff @(posedge clk_sys) begin
		if (ioctl_wr & cart_download) begin
			if (ioctl_addr == '0)
				cart_mask <= '0;
			else
				cart_mask <= cart_mask | ioctl_addr[ROM_ADDR_W-1:0];
			if (ioctl_addr == IOCTL_ADDR_W'(SECTOR_BYTES))
				cart_mask512 <= '0;
			else if (ioctl_addr > IOCTL_ADDR_W'(SECTOR_BYTES))
				cart_mask512 <= cart_mask512 |
					(ioctl_addr[ROM_ADDR_W-1:0] - ROM_ADDR_W'(SECTOR_BYTES));
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			gg         <= 1'b0;
			cart_sz512 <= 1'b0;
		end else begin
			if (ioctl_wr & cart_download)
				gg <= (ioctl_index[4:0] == GG_INDEX);
			// Header present when the image ends in an odd 512 byte block
			if (old_download & ~cart_download)
				cart_sz512 <= ioctl_addr[9];
		end
	end

	assign rom_addr = cart_sz512 ?
		(rom_raddr + ROM_ADDR_W'(SECTOR_BYTES)) & cart_mask512 :
		rom_raddr & cart_mask;

endmodule

/* sms_pkg.sv */
package sms_pkg;

	// ========================================================================
	// Host sector geometry
	// ========================================================================

	// Bytes per sector, also the size of an optional cartridge header
	localparam int SECTOR_BYTES  = 512;
	localparam int SECTOR_ADDR_W = 9;

	// ========================================================================
	// Cartridge download and ROM addressing
	// ========================================================================

	// Console side read address into the cartridge image
	localparam int ROM_ADDR_W   = 22;
	// Write side address into external ROM memory
	localparam int ROM_WADDR_W  = 24;
	localparam int IOCTL_ADDR_W = 25;

	// Download index with every bit set carries a cheat file
	localparam logic [7:0] CODE_INDEX = 8'hff;
	// Low index bits that select a Game Gear cart
	localparam logic [4:0] GG_INDEX   = 5'd2;

	// ========================================================================
	// Cheat code word
	// ========================================================================

	// Flat view is filled byte by byte during the download,
	// field view is what the cheat engine consumes
	typedef union packed {
		logic [15:0][7:0] bytes;
		struct packed {
			logic [31:0] flags;
			logic [31:0] addr;
			logic [31:0] compare;
			logic [31:0] replace;
		} fields;
	} cheat_code_t;

endpackage

/* tb_cart_host.sv */
`timescale 1ns/100ps

module tb_cart_host import sms_pkg::*; ;

	localparam int BK_SECTORS = 4;
	localparam int RAM_BYTES  = BK_SECTORS * SECTOR_BYTES;
	localparam int NV_W       = $clog2(BK_SECTORS) + SECTOR_ADDR_W;

	logic clk_sys, reset;
	logic ioctl_download, ioctl_wr, ioctl_wait;
	logic [7:0] ioctl_index, ioctl_dout;
	logic [IOCTL_ADDR_W-1:0] ioctl_addr;
	logic rom_wr, rom_we_ack, gg;
	logic [ROM_WADDR_W-1:0] rom_waddr;
	logic [7:0] rom_wdata;
	logic [ROM_ADDR_W-1:0] rom_raddr, rom_addr;
	logic [31:0] sd_lba;
	logic sd_rd, sd_wr, sd_ack, sd_buff_wr, sd_buff_stall;
	logic [SECTOR_ADDR_W-1:0] sd_buff_addr;
	logic [7:0] sd_buff_dout, sd_buff_din;
	logic img_mounted, img_readonly, img_size_nz;
	logic bk_load, bk_save, autosave, osd_open;
	logic nvram_sel, nvram_we;
	logic [NV_W-1:0] nvram_a;
	logic [7:0] nvram_d, nvram_q;
	logic bk_busy, bk_pending, console_reset, bk_led, code_valid;
	cheat_code_t code;

	string       tags [$];
	string       ops [$];
	logic [31:0] args [$];
	logic [31:0] datas [$];
	logic [31:0] exps [$];
	logic [7:0]  shadow [RAM_BYTES];
	integer      seed_v;
	int          budget;
	int          test_errs;
	string       cur_tag;
	bit          xfer_done;

	cart_host_top #(.BK_SECTORS(BK_SECTORS)) u_dut (
		.clk_sys(clk_sys), .reset(reset),
		.ioctl_download(ioctl_download), .ioctl_index(ioctl_index),
		.ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout), .ioctl_wr(ioctl_wr),
		.ioctl_wait(ioctl_wait), .rom_wr(rom_wr), .rom_waddr(rom_waddr),
		.rom_wdata(rom_wdata), .rom_we_ack(rom_we_ack), .rom_raddr(rom_raddr),
		.rom_addr(rom_addr), .gg(gg), .sd_lba(sd_lba), .sd_rd(sd_rd), .sd_wr(sd_wr),
		.sd_ack(sd_ack), .sd_buff_addr(sd_buff_addr), .sd_buff_wr(sd_buff_wr),
		.sd_buff_dout(sd_buff_dout), .sd_buff_din(sd_buff_din),
		.sd_buff_stall(sd_buff_stall), .img_mounted(img_mounted),
		.img_readonly(img_readonly), .img_size_nz(img_size_nz), .bk_load(bk_load),
		.bk_save(bk_save), .autosave(autosave), .osd_open(osd_open),
		.nvram_sel(nvram_sel), .nvram_a(nvram_a), .nvram_we(nvram_we),
		.nvram_d(nvram_d), .nvram_q(nvram_q), .bk_busy(bk_busy),
		.bk_pending(bk_pending), .console_reset(console_reset), .bk_led(bk_led),
		.code(code), .code_valid(code_valid)
	);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	// Byte patterns for cart image and backup RAM that depend on the whole address
	function automatic logic [7:0] cart_byte(input int a, input logic [7:0] seed);
		logic [15:0] aa;
		aa = a;
		return (aa[7:0] * 8'h1d + aa[15:8]) ^ seed;
	endfunction

	function automatic logic [7:0] ram_byte(input int a, input logic [7:0] seed);
		logic [10:0] aa;
		aa = a;
		return (aa[7:0] + aa[10:8] * 8'h3b) ^ seed;
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		if (exp !== act) begin
			test_errs++;
			if (test_errs <= 4)
				$display("FAILED %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic report_error(input string msg);
		test_errs++;
		if (test_errs <= 4)
			$display("ERROR in %s: %s", cur_tag, msg);
	endtask

	// ========================================================================
	// Host download with ROM memory model
	// ========================================================================
	task automatic download_cart(input int count, input logic [7:0] index,
		input logic [7:0] seed, output int toggles);
		logic [7:0] b;
		logic       last_wr;
		int         d;
		int         t;
		toggles = 0;
		@(posedge clk_sys);
		ioctl_index    <= index;
		ioctl_download <= 1'b1;
		@(posedge clk_sys);
		for (int i = 0; i < count; i++) begin
			b = cart_byte(i, seed);
			last_wr = rom_wr;
			@(posedge clk_sys);
			ioctl_wr   <= 1'b1;
			ioctl_addr <= i;
			ioctl_dout <= b;
			@(posedge clk_sys);
			ioctl_wr <= 1'b0;
			@(negedge clk_sys);
			if (rom_wr !== last_wr)
				toggles++;
			else
				report_error("byte was not forwarded as a ROM write toggle");
			check_value({cur_tag, " waddr"}, i, rom_waddr);
			check_value({cur_tag, " wdata"}, b, rom_wdata);
			if (!console_reset)
				report_error("console_reset low during cart download");
			d = 1 + ($unsigned($random(seed_v)) % 8);
			repeat (d - 1) begin
				if (!ioctl_wait)
					report_error("ioctl_wait low before the acknowledge");
				@(negedge clk_sys);
			end
			if (!ioctl_wait)
				report_error("ioctl_wait low before the acknowledge");
			@(posedge clk_sys);
			rom_we_ack <= rom_wr;
			t = 0;
			@(negedge clk_sys);
			while (ioctl_wait && t < 4) begin
				t++;
				@(negedge clk_sys);
			end
			if (ioctl_wait)
				report_error("ioctl_wait stuck after the acknowledge");
		end
		// Writable save image mounted before the download ends
		@(posedge clk_sys);
		img_mounted <= 1'b1;
		@(posedge clk_sys);
		img_mounted    <= 1'b0;
		ioctl_download <= 1'b0;
		repeat (3) @(posedge clk_sys);
	endtask

	task automatic download_cheat(input logic [7:0] seed, output int pulses);
		pulses = 0;
		@(posedge clk_sys);
		ioctl_index    <= CODE_INDEX;
		ioctl_download <= 1'b1;
		for (int n = 0; n < 16; n++) begin
			@(posedge clk_sys);
			ioctl_wr   <= 1'b1;
			ioctl_addr <= n;
			ioctl_dout <= seed + 8'(n * 8'h11);
			@(negedge clk_sys);
			pulses += code_valid;
			@(posedge clk_sys);
			ioctl_wr <= 1'b0;
			@(negedge clk_sys);
			pulses += code_valid;
		end
		repeat (3) begin
			@(negedge clk_sys);
			pulses += code_valid;
		end
		@(posedge clk_sys);
		ioctl_download <= 1'b0;
		ioctl_index    <= 8'h00;
	endtask

	// ========================================================================
	// Console backup port model
	// ========================================================================
	task automatic console_write(input int a, input logic [7:0] d, output bit stalled);
		@(posedge clk_sys);
		nvram_sel <= 1'b1;
		nvram_we  <= 1'b1;
		nvram_a   <= a;
		nvram_d   <= d;
		@(negedge clk_sys);
		stalled = sd_buff_stall;
		@(posedge clk_sys);
		nvram_sel <= 1'b0;
		nvram_we  <= 1'b0;
		shadow[a] = d;
	endtask

	task automatic console_read(input int a, output logic [7:0] q);
		@(posedge clk_sys);
		nvram_sel <= 1'b1;
		nvram_we  <= 1'b0;
		nvram_a   <= a;
		@(posedge clk_sys);
		nvram_sel <= 1'b0;
		@(negedge clk_sys);
		q = nvram_q;
	endtask

	// Random console reads that compete with the sector buffer
	task automatic console_traffic();
		logic [7:0] q;
		int         a;
		while (!xfer_done) begin
			if (($random(seed_v) & 3) == 0) begin
				a = $unsigned($random(seed_v)) % RAM_BYTES;
				console_read(a, q);
				check_value({cur_tag, " nvram_q"}, shadow[a], q);
			end else begin
				@(posedge clk_sys);
			end
		end
	endtask

	// ========================================================================
	// Host sector buffer model
	// ========================================================================
	task automatic serve_transfer(input bit load, input logic [7:0] seed,
		output int sectors);
		int i;
		int t;
		int prev;
		bit have_prev;
		sectors = 0;
		for (int s = 0; s < BK_SECTORS; s++) begin
			t = 0;
			@(negedge clk_sys);
			while (!(load ? sd_rd : sd_wr) && t < 100) begin
				t++;
				@(negedge clk_sys);
			end
			if (!(load ? sd_rd : sd_wr)) begin
				report_error("no sector request from the sequencer");
				return;
			end
			check_value({cur_tag, " sd_lba"}, s, sd_lba);
			@(posedge clk_sys);
			sd_ack <= 1'b1;
			i = 0;
			have_prev = 0;
			while (i < SECTOR_BYTES || have_prev) begin
				@(posedge clk_sys);
				sd_buff_addr <= i;
				sd_buff_wr   <= load && (i < SECTOR_BYTES);
				sd_buff_dout <= ram_byte(s * SECTOR_BYTES + i, seed);
				@(negedge clk_sys);
				if (load && !console_reset)
					report_error("console_reset low during backup load");
				if (have_prev)
					check_value({cur_tag, " sd_buff_din"},
						shadow[s * SECTOR_BYTES + prev], sd_buff_din);
				have_prev = 0;
				if (i < SECTOR_BYTES && !sd_buff_stall) begin
					if (load)
						shadow[s * SECTOR_BYTES + i] = ram_byte(s * SECTOR_BYTES + i, seed);
					else begin
						have_prev = 1;
						prev = i;
					end
					i++;
				end
			end
			@(posedge clk_sys);
			sd_ack     <= 1'b0;
			sd_buff_wr <= 1'b0;
			sectors++;
		end
		t = 0;
		@(negedge clk_sys);
		while (bk_busy && t < 20) begin
			t++;
			@(negedge clk_sys);
		end
		if (bk_busy)
			report_error("bk_busy did not fall after the last sector");
	endtask

	task automatic save_with_traffic(output int sectors);
		xfer_done = 0;
		fork
			begin
				serve_transfer(1'b0, 8'h00, sectors);
				xfer_done = 1;
			end
			console_traffic();
		join
	endtask

	// ========================================================================
	// Test sequence
	// ========================================================================
	initial begin
		int fd;
		int n;
		int act;
		int passed;
		int failed;
		string line;
		string tag;
		string op;
		logic [31:0] a;
		logic [31:0] d;
		logic [31:0] e;
		logic [7:0]  q;
		bit          st;

		seed_v = 32'h5e06;
		budget = 0;
		passed = 0;
		failed = 0;
		reset = 1'b1;
		ioctl_download = 0;
		ioctl_wr = 0;
		ioctl_index = 0;
		ioctl_addr = 0;
		ioctl_dout = 0;
		rom_we_ack = 0;
		rom_raddr = 0;
		sd_ack = 0;
		sd_buff_addr = 0;
		sd_buff_wr = 0;
		sd_buff_dout = 0;
		img_mounted = 0;
		img_readonly = 0;
		img_size_nz = 0;
		bk_load = 0;
		bk_save = 0;
		autosave = 0;
		osd_open = 0;
		nvram_sel = 0;
		nvram_a = 0;
		nvram_we = 0;
		nvram_d = 0;

		fd = $fopen("cart_host_patterns.txt", "r");
		if (fd == 0) begin
			$display("Could not open the pattern file cart_host_patterns.txt");
			failed++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				n = $fgets(line, fd);
				if (n > 1 && line.getc(0) != "#") begin
					if ($sscanf(line, "%s %s %h %h %h", tag, op, a, d, e) == 5) begin
						tags.push_back(tag);
						ops.push_back(op);
						args.push_back(a);
						datas.push_back(d);
						exps.push_back(e);
					end
				end
			end
			$fclose(fd);
		end

		// Cycle budget for the watchdog
		budget = 200 * (tags.size() + 1);
		foreach (ops[k]) begin
			if (ops[k] == "CART")
				budget += 14 * args[k];
			else if (ops[k] == "CWR" || ops[k] == "CRD")
				budget += 4 * args[k];
			else if (ops[k] == "SAVE" || ops[k] == "LOAD" || ops[k] == "AUTO")
				budget += 4000;
		end

		repeat (8) @(posedge clk_sys);
		reset <= 1'b0;
		@(posedge clk_sys);

		foreach (tags[k]) begin
			cur_tag = tags[k];
			test_errs = 0;
			act = 0;
			if (ops[k] == "CART") begin
				download_cart(args[k], datas[k][15:8], datas[k][7:0], act);
				check_value(cur_tag, exps[k], act);
			end else if (ops[k] == "RDA") begin
				@(posedge clk_sys);
				rom_raddr <= args[k];
				@(negedge clk_sys);
				check_value(cur_tag, exps[k], rom_addr);
			end else if (ops[k] == "GG") begin
				check_value(cur_tag, exps[k], gg);
			end else if (ops[k] == "CODE") begin
				download_cheat(datas[k][7:0], act);
				check_value(cur_tag, exps[k], act);
			end else if (ops[k] == "FLG") begin
				check_value(cur_tag, exps[k], code.fields.flags);
			end else if (ops[k] == "ADR") begin
				check_value(cur_tag, exps[k], code.fields.addr);
			end else if (ops[k] == "CMP") begin
				check_value(cur_tag, exps[k], code.fields.compare);
			end else if (ops[k] == "REP") begin
				check_value(cur_tag, exps[k], code.fields.replace);
			end else if (ops[k] == "CWR") begin
				// Counts console writes that stalled the sector buffer
				for (int i = 0; i < args[k]; i++) begin
					console_write(i, ram_byte(i, datas[k][7:0]), st);
					act += st;
				end
				check_value(cur_tag, exps[k], act);
			end else if (ops[k] == "CRD") begin
				for (int i = 0; i < args[k]; i++) begin
					console_read(i, q);
					if (q === shadow[i])
						act++;
					else
						check_value({cur_tag, " nvram_q"}, shadow[i], q);
				end
				check_value(cur_tag, exps[k], act);
			end else if (ops[k] == "SAVE") begin
				@(posedge clk_sys);
				bk_save <= 1'b1;
				save_with_traffic(act);
				@(posedge clk_sys);
				bk_save <= 1'b0;
				check_value(cur_tag, exps[k], act);
			end else if (ops[k] == "LOAD") begin
				@(posedge clk_sys);
				bk_load <= 1'b1;
				serve_transfer(1'b1, datas[k][7:0], act);
				@(posedge clk_sys);
				bk_load <= 1'b0;
				check_value(cur_tag, exps[k], act);
			end else if (ops[k] == "AUTO") begin
				@(posedge clk_sys);
				autosave <= 1'b1;
				console_write(args[k], datas[k][7:0], st);
				@(negedge clk_sys);
				check_value({cur_tag, " bk_pending"}, 1, bk_pending);
				check_value({cur_tag, " bk_led"}, 1, bk_led);
				@(posedge clk_sys);
				osd_open <= 1'b1;
				save_with_traffic(act);
				check_value({cur_tag, " bk_pending"}, 0, bk_pending);
				@(posedge clk_sys);
				osd_open <= 1'b0;
				autosave <= 1'b0;
				check_value(cur_tag, exps[k], act);
			end else begin
				report_error({"unknown operation ", ops[k]});
			end
			if (test_errs == 0) begin
				passed++;
				$display("test %s: ok", cur_tag);
			end else begin
				failed++;
				$display("test %s: %0d errors", cur_tag, test_errs);
			end
		end

		$display("tests run %0d, passed %0d, failed %0d", passed + failed, passed, failed);
		if (failed == 0 && passed > 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	// Watchdog armed once the pattern file has been read
	initial begin
		wait (budget > 0);
		repeat (budget + 8) @(posedge clk_sys);
		$display("Watchdog expired, the run took longer than its cycle budget");
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule
